/* Bender.yml */
package:
  name: lsp_compose

sources:
  - files:
      - source/lsp_compose_pkg.sv
      - source/lsp_coef_store.sv
      - source/lsp_element_feed.sv
      - source/ma_tap_product.sv
      - source/lsp_accumulate.sv
      - source/lsp_compose_top.sv
  - target: test
    files:
      - verification/lsp_compose_tb.sv

/* filelist.f */
source/lsp_compose_pkg.sv
source/lsp_coef_store.sv
source/lsp_element_feed.sv
source/ma_tap_product.sv
source/lsp_accumulate.sv
source/lsp_compose_top.sv
verification/lsp_compose_tb.sv

/* source/lsp_accumulate.sv */
`default_nettype none

module lsp_accumulate
	import lsp_compose_pkg::*;
#(
	parameter int LPC_ORDER = 10,
	parameter int MA_ORDER  = 4
)
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  elem_valid,
	input  wire elem_index_t           elem_index,
	input  wire q15_t                  elem_lsp_ele,
	input  wire q15_t                  elem_fg_sum,
	input  wire acc_t [MA_ORDER-1:0]   tap_product,
	output logic                       lsp_valid,
	output elem_index_t                lsp_index,
	output q15_t                       lsp_value,
	output logic                       done
);

	acc_t        base_prod;
	logic        s1_valid;
	elem_index_t s1_index;
	acc_t        sum;
	logic        s1_last;

	////////////////////////////////////////////////////////////
	// Stage one, base product in step with the tap lanes
	always_ff @(posedge clk)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= elem_valid;
	end

	always_ff @(posedge clk)
	begin
		base_prod <= l_mult(elem_lsp_ele, elem_fg_sum);
		s1_index  <= elem_index;
	end

	////////////////////////////////////////////////////////////
	// Stage two, taps added in order k = 0 upward
	// Saturation makes the order matter
	always_comb
	begin
		sum = base_prod;
		for (int k = 0; k < MA_ORDER; k++)
			sum = l_add(sum, tap_product[k]);
	end

	assign s1_last = s1_valid && (s1_index == elem_index_t'(LPC_ORDER - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lsp_valid <= 1'b0;
			done      <= 1'b0;
		end
		else
		begin
			lsp_valid <= s1_valid;
			done      <= s1_last;
		end
	end

	// High word, truncated
	always_ff @(posedge clk)
	begin
		lsp_index <= s1_index;
		lsp_value <= sum[31:16];
	end

endmodule

`default_nettype wire

/* source/lsp_coef_store.sv */
`default_nettype none

module lsp_coef_store
	import lsp_compose_pkg::*;
#(
	parameter int LPC_ORDER = 10,
	parameter int MA_ORDER  = 4
)
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  load_en,
	input  wire table_sel_t            load_sel,
	input  wire tap_index_t            load_tap,
	input  wire elem_index_t           load_index,
	input  wire q15_t                  load_data,
	input  wire elem_index_t           feed_index,
	output q15_t                       rd_lsp_ele,
	output q15_t                       rd_fg_sum,
	output q15_t [MA_ORDER-1:0]        rd_fg,
	output q15_t [MA_ORDER-1:0]        rd_freq_prev
);

	q15_t lsp_ele_tab   [LPC_ORDER];
	q15_t fg_sum_tab    [LPC_ORDER];
	q15_t fg_tab        [MA_ORDER][LPC_ORDER];
	q15_t freq_prev_tab [MA_ORDER][LPC_ORDER];

	logic index_ok;
	logic tap_ok;

	// Writes outside the configured orders are dropped
	assign index_ok = int'(load_index) < LPC_ORDER;
	assign tap_ok   = int'(load_tap) < MA_ORDER;

	////////////////////////////////////////////////////////////
	// Host write port
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int j = 0; j < LPC_ORDER; j++)
			begin
				lsp_ele_tab[j] <= '0;
				fg_sum_tab[j]  <= '0;
				for (int k = 0; k < MA_ORDER; k++)
				begin
					fg_tab[k][j]        <= '0;
					freq_prev_tab[k][j] <= '0;
				end
			end
		end
		else if (load_en && index_ok)
		begin
			case (load_sel)
				SEL_LSP_ELE:
					lsp_ele_tab[load_index] <= load_data;
				SEL_FG_SUM:
					fg_sum_tab[load_index] <= load_data;
				SEL_FG:
					if (tap_ok)
						fg_tab[load_tap][load_index] <= load_data;
				SEL_FREQ_PREV:
					if (tap_ok)
						freq_prev_tab[load_tap][load_index] <= load_data;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// All taps of one element at once
	always_comb
	begin
		rd_lsp_ele = lsp_ele_tab[feed_index];
		rd_fg_sum  = fg_sum_tab[feed_index];
		for (int k = 0; k < MA_ORDER; k++)
		begin
			rd_fg[k]        = fg_tab[k][feed_index];
			rd_freq_prev[k] = freq_prev_tab[k][feed_index];
		end
	end

endmodule

`default_nettype wire

/* source/lsp_compose_pkg.sv */
`default_nettype none

package lsp_compose_pkg;

	// Q15 fraction and Q31 accumulator
	typedef logic signed [15:0] q15_t;
	typedef logic signed [31:0] acc_t;

	typedef logic [3:0] elem_index_t;
	typedef logic [1:0] tap_index_t;
	typedef logic [1:0] table_sel_t;

	// Host table select codes
	localparam table_sel_t SEL_LSP_ELE   = 2'd0;
	localparam table_sel_t SEL_FG_SUM    = 2'd1;
	localparam table_sel_t SEL_FG        = 2'd2;
	localparam table_sel_t SEL_FREQ_PREV = 2'd3;

	localparam acc_t ACC_MAX = 32'sh7fff_ffff;
	localparam acc_t ACC_MIN = 32'sh8000_0000;
	localparam q15_t Q15_MIN = 16'sh8000;

	// Doubling product, only -1 * -1 can overflow
	function automatic acc_t l_mult(input q15_t a, input q15_t b);
		acc_t prod;
		if ((a == Q15_MIN) && (b == Q15_MIN))
		begin
			return ACC_MAX;
		end
		prod = acc_t'(a) * acc_t'(b);
		return prod <<< 1;
	endfunction

	// Saturating add, overflow when the signs agree and the result flips
	function automatic acc_t l_add(input acc_t a, input acc_t b);
		acc_t sum;
		sum = a + b;
		if ((a[31] == b[31]) && (sum[31] != a[31]))
		begin
			sum = a[31] ? ACC_MIN : ACC_MAX;
		end
		return sum;
	endfunction

endpackage

`default_nettype wire

/* source/lsp_compose_top.sv */
`default_nettype none

module lsp_compose_top
	import lsp_compose_pkg::*;
#(
	parameter int LPC_ORDER = 10,
	parameter int MA_ORDER  = 4
)
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        start,
	input  wire logic        load_en,
	input  wire table_sel_t  load_sel,
	input  wire tap_index_t  load_tap,
	input  wire elem_index_t load_index,
	input  wire q15_t        load_data,
	output logic             busy,
	output logic             lsp_valid,
	output elem_index_t      lsp_index,
	output q15_t             lsp_value,
	output logic             done
);

	// Store read side
	elem_index_t          feed_index;
	q15_t                 rd_lsp_ele;
	q15_t                 rd_fg_sum;
	q15_t [MA_ORDER-1:0]  rd_fg;
	q15_t [MA_ORDER-1:0]  rd_freq_prev;

	// Feeder outputs
	logic                 elem_valid;
	elem_index_t          elem_index;
	q15_t                 elem_lsp_ele;
	q15_t                 elem_fg_sum;
	q15_t [MA_ORDER-1:0]  elem_fg;
	q15_t [MA_ORDER-1:0]  elem_freq_prev;

	acc_t [MA_ORDER-1:0]  tap_product;

	////////////////////////////////////////////////////////////
	lsp_coef_store #(
		.LPC_ORDER (LPC_ORDER),
		.MA_ORDER  (MA_ORDER)
	) u_store (
		.clk          (clk),
		.reset        (reset),
		.load_en      (load_en),
		.load_sel     (load_sel),
		.load_tap     (load_tap),
		.load_index   (load_index),
		.load_data    (load_data),
		.feed_index   (feed_index),
		.rd_lsp_ele   (rd_lsp_ele),
		.rd_fg_sum    (rd_fg_sum),
		.rd_fg        (rd_fg),
		.rd_freq_prev (rd_freq_prev)
	);

	lsp_element_feed #(
		.LPC_ORDER (LPC_ORDER),
		.MA_ORDER  (MA_ORDER)
	) u_feed (
		.clk            (clk),
		.reset          (reset),
		.start          (start),
		.rd_lsp_ele     (rd_lsp_ele),
		.rd_fg_sum      (rd_fg_sum),
		.rd_fg          (rd_fg),
		.rd_freq_prev   (rd_freq_prev),
		.busy           (busy),
		.feed_index     (feed_index),
		.elem_valid     (elem_valid),
		.elem_index     (elem_index),
		.elem_lsp_ele   (elem_lsp_ele),
		.elem_fg_sum    (elem_fg_sum),
		.elem_fg        (elem_fg),
		.elem_freq_prev (elem_freq_prev)
	);

	////////////////////////////////////////////////////////////
	// One product lane per MA tap
	for (genvar k = 0; k < MA_ORDER; k++)
	begin : g_tap
		ma_tap_product u_tap (
			.clk         (clk),
			.freq_prev   (elem_freq_prev[k]),
			.fg          (elem_fg[k]),
			.tap_product (tap_product[k])
		);
	end

	lsp_accumulate #(
		.LPC_ORDER (LPC_ORDER),
		.MA_ORDER  (MA_ORDER)
	) u_acc (
		.clk          (clk),
		.reset        (reset),
		.elem_valid   (elem_valid),
		.elem_index   (elem_index),
		.elem_lsp_ele (elem_lsp_ele),
		.elem_fg_sum  (elem_fg_sum),
		.tap_product  (tap_product),
		.lsp_valid    (lsp_valid),
		.lsp_index    (lsp_index),
		.lsp_value    (lsp_value),
		.done         (done)
	);

endmodule

`default_nettype wire

/* source/lsp_element_feed.sv */
`default_nettype none

module lsp_element_feed
	import lsp_compose_pkg::*;
#(
	parameter int LPC_ORDER = 10,
	parameter int MA_ORDER  = 4
)
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  start,
	input  wire q15_t                  rd_lsp_ele,
	input  wire q15_t                  rd_fg_sum,
	input  wire q15_t [MA_ORDER-1:0]   rd_fg,
	input  wire q15_t [MA_ORDER-1:0]   rd_freq_prev,
	output logic                       busy,
	output elem_index_t                feed_index,
	output logic                       elem_valid,
	output elem_index_t                elem_index,
	output q15_t                       elem_lsp_ele,
	output q15_t                       elem_fg_sum,
	output q15_t [MA_ORDER-1:0]        elem_fg,
	output q15_t [MA_ORDER-1:0]        elem_freq_prev
);

	typedef enum logic [1:0] {IDLE, RUN, FLUSH} feed_state_t;

	// Tap lane, accumulator sum and output register
	localparam int DRAIN_CYCLES = 3;

	feed_state_t state;
	logic [1:0]  drain_cnt;
	logic        last_elem;

	assign last_elem = feed_index == elem_index_t'(LPC_ORDER - 1);
	assign busy      = state != IDLE;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= IDLE;
			feed_index <= '0;
			drain_cnt  <= '0;
			elem_valid <= 1'b0;
		end
		else
		begin
			elem_valid <= 1'b0;
			case (state)
				IDLE:
					if (start)
					begin
						feed_index <= '0;
						state      <= RUN;
					end
				RUN:
				begin
					elem_valid <= 1'b1;
					if (last_elem)
					begin
						drain_cnt <= '0;
						state     <= FLUSH;
					end
					else
						feed_index <= feed_index + 1'b1;
				end
				FLUSH:
					if (drain_cnt == 2'(DRAIN_CYCLES - 1))
						state <= IDLE;
					else
						drain_cnt <= drain_cnt + 1'b1;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Operands only mean something while elem_valid is high
	always_ff @(posedge clk)
	begin
		elem_index     <= feed_index;
		elem_lsp_ele   <= rd_lsp_ele;
		elem_fg_sum    <= rd_fg_sum;
		elem_fg        <= rd_fg;
		elem_freq_prev <= rd_freq_prev;
	end

endmodule

`default_nettype wire

/* source/ma_tap_product.sv */
`default_nettype none

module ma_tap_product
	import lsp_compose_pkg::*;
(
	input  wire logic clk,
	input  wire q15_t freq_prev,
	input  wire q15_t fg,
	output acc_t      tap_product
);

	// freq_prev[k][j] * fg[k][j] in Q31
	always_ff @(posedge clk)
	begin
		tap_product <= l_mult(freq_prev, fg);
	end

endmodule

`default_nettype wire

/* verification/lsp_compose_tb.sv */
`default_nettype none

module lsp_compose_tb
	import lsp_compose_pkg::*;
;

	localparam int LPC_ORDER = 10;
	localparam int MA_ORDER  = 4;

	// Run limit from the test lengths, with 100% margin
	localparam int LOADS_PER_FRAME = 2 * LPC_ORDER + 2 * MA_ORDER * LPC_ORDER;
	localparam int FRAME_CYCLES    = 20;
	localparam int N_FRAMES        = 6;
	localparam int TIMEOUT_CYCLES  = 2 * N_FRAMES * (LOADS_PER_FRAME + FRAME_CYCLES);

	logic        clk;
	logic        reset;
	logic        start;
	logic        load_en;
	table_sel_t  load_sel;
	tap_index_t  load_tap;
	elem_index_t load_index;
	q15_t        load_data;
	logic        busy;
	logic        lsp_valid;
	elem_index_t lsp_index;
	q15_t        lsp_value;
	logic        done;

	// Shadow copy of the tables and the expected results
	q15_t sh_lsp_ele   [LPC_ORDER];
	q15_t sh_fg_sum    [LPC_ORDER];
	q15_t sh_fg        [MA_ORDER][LPC_ORDER];
	q15_t sh_freq_prev [MA_ORDER][LPC_ORDER];
	q15_t exp_value    [16];

	logic [31:0] lfsr_state = 32'd97726;
	int          cycle_cnt = 0;
	int          accept_cycle = 0;
	int          results_total = 0;
	int          done_total = 0;
	int          error_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	elem_index_t expect_index = '0;

	lsp_compose_top #(
		.LPC_ORDER (LPC_ORDER),
		.MA_ORDER  (MA_ORDER)
	) u_dut (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.load_en    (load_en),
		.load_sel   (load_sel),
		.load_tap   (load_tap),
		.load_index (load_index),
		.load_data  (load_data),
		.busy       (busy),
		.lsp_valid  (lsp_valid),
		.lsp_index  (lsp_index),
		.lsp_value  (lsp_value),
		.done       (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference arithmetic, widened and clamped
	function automatic acc_t clamp32(input longint v);
		if (v > longint'(32'sh7fff_ffff))
			return 32'sh7fff_ffff;
		if (v < -longint'(64'h8000_0000))
			return 32'sh8000_0000;
		return acc_t'(v);
	endfunction

	function automatic acc_t ref_mult(input q15_t a, input q15_t b);
		return clamp32(longint'(a) * longint'(b) * 2);
	endfunction

	function automatic acc_t ref_add(input acc_t a, input acc_t b);
		return clamp32(longint'(a) + longint'(b));
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[14:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic q15_t extreme(input int n);
		case (n % 4)
			0: return 16'sh8000;
			1: return 16'sh7fff;
			2: return 16'sh8001;
			default: return 16'sh4000;
		endcase
	endfunction

	task automatic compute_expected();
		acc_t acc;
		for (int j = 0; j < LPC_ORDER; j++)
		begin
			acc = ref_mult(sh_lsp_ele[j], sh_fg_sum[j]);
			for (int k = 0; k < MA_ORDER; k++)
				acc = ref_add(acc, ref_mult(sh_freq_prev[k][j], sh_fg[k][j]));
			exp_value[j] = acc[31:16];
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	task automatic write_entry(input table_sel_t sel, input int tap, input int idx,
			input q15_t data);
		@(posedge clk);
		load_en    <= 1'b1;
		load_sel   <= sel;
		load_tap   <= tap_index_t'(tap);
		load_index <= elem_index_t'(idx);
		load_data  <= data;
	endtask

	task automatic write_all_tables();
		for (int j = 0; j < LPC_ORDER; j++)
		begin
			write_entry(SEL_LSP_ELE, 0, j, sh_lsp_ele[j]);
			write_entry(SEL_FG_SUM, 0, j, sh_fg_sum[j]);
			for (int k = 0; k < MA_ORDER; k++)
			begin
				write_entry(SEL_FG, k, j, sh_fg[k][j]);
				write_entry(SEL_FREQ_PREV, k, j, sh_freq_prev[k][j]);
			end
		end
		@(posedge clk);
		load_en <= 1'b0;
		compute_expected();
	endtask

	task automatic fill_random();
		for (int j = 0; j < LPC_ORDER; j++)
		begin
			sh_lsp_ele[j] = rand_bits(16);
			sh_fg_sum[j]  = rand_bits(16);
			for (int k = 0; k < MA_ORDER; k++)
			begin
				sh_fg[k][j]        = rand_bits(16);
				sh_freq_prev[k][j] = rand_bits(16);
			end
		end
	endtask

	// Element 0 all -1, element 1 all large negative terms, the rest mixed
	task automatic fill_saturation();
		for (int j = 0; j < LPC_ORDER; j++)
		begin
			sh_lsp_ele[j] = (j < 2) ? 16'sh8000 : extreme(j);
			sh_fg_sum[j]  = (j == 0) ? 16'sh8000 : (j == 1) ? 16'sh7fff : extreme(j + 1);
			for (int k = 0; k < MA_ORDER; k++)
			begin
				sh_freq_prev[k][j] = (j < 2) ? 16'sh8000 : extreme(j + 2 * k);
				sh_fg[k][j] = (j == 0) ? 16'sh8000 : (j == 1) ? 16'sh7fff : extreme(j * k + 3);
			end
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_idle();
		do
			@(posedge clk);
		while (busy !== 1'b0);
	endtask

	// One frame, then check how many results and done pulses it gave
	task automatic run_frame(input int extra_start);
		int res_before;
		int done_before;
		res_before  = results_total;
		done_before = done_total;
		pulse_start();
		if (extra_start)
		begin
			repeat (4) @(posedge clk);
			pulse_start();
		end
		wait_idle();
		assert (results_total - res_before == LPC_ORDER)
		else
		begin
			error_count++;
			$display("Frame produced %0d results instead of %0d",
				results_total - res_before, LPC_ORDER);
		end
		assert (done_total - done_before == 1)
		else
		begin
			error_count++;
			$display("done pulsed %0d times in one frame", done_total - done_before);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor and timeout
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (!reset && start && busy === 1'b0)
		begin
			accept_cycle <= cycle_cnt;
			expect_index <= '0;
		end
		if (lsp_valid === 1'b1)
		begin
			results_total <= results_total + 1;
			expect_index  <= expect_index + 1'b1;
		end
		if (done === 1'b1)
			done_total <= done_total + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !lsp_valid && !done && !busy)
	else
	begin
		error_count++;
		$display("Error at %0t: outputs not idle right after reset", $time);
	end

	a_value: assert property (@(posedge clk) disable iff (reset)
		lsp_valid |-> lsp_value == exp_value[lsp_index])
	else
	begin
		error_count++;
		$display("Error at %0t: lsp_value %h for index %0d, expected %h", $time,
			$sampled(lsp_value), $sampled(lsp_index), exp_value[$sampled(lsp_index)]);
	end

	// High from the edge j+3 after start, seen at the edge that follows
	a_timing: assert property (@(posedge clk) disable iff (reset)
		lsp_valid |-> cycle_cnt == accept_cycle + int'(lsp_index) + 4)
	else
	begin
		error_count++;
		$display("Error at %0t: index %0d came at the wrong cycle", $time, $sampled(lsp_index));
	end

	a_order: assert property (@(posedge clk) disable iff (reset)
		lsp_valid |-> lsp_index == expect_index)
	else
	begin
		error_count++;
		$display("Error at %0t: index %0d out of order", $time, $sampled(lsp_index));
	end

	a_done_last: assert property (@(posedge clk) disable iff (reset)
		done |-> lsp_valid && lsp_index == elem_index_t'(LPC_ORDER - 1))
	else
	begin
		error_count++;
		$display("Error at %0t: done without the last element", $time);
	end

	a_done_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
	else
	begin
		error_count++;
		$display("Error at %0t: busy already low with done", $time);
	end

	a_busy_fall: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
	else
	begin
		error_count++;
		$display("Error at %0t: busy still high one cycle after done", $time);
	end

	////////////////////////////////////////////////////////////
	initial
	begin
		int errors_before;
		reset      = 1'b1;
		start      = 1'b0;
		load_en    = 1'b0;
		load_sel   = '0;
		load_tap   = '0;
		load_index = '0;
		load_data  = '0;
		for (int j = 0; j < LPC_ORDER; j++)
		begin
			sh_lsp_ele[j] = '0;
			sh_fg_sum[j]  = '0;
			for (int k = 0; k < MA_ORDER; k++)
			begin
				sh_fg[k][j]        = '0;
				sh_freq_prev[k][j] = '0;
			end
		end
		compute_expected();
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		errors_before = error_count;
		run_frame(0);
		report_test("reset and zero tables", errors_before);

		errors_before = error_count;
		fill_random();
		write_all_tables();
		run_frame(0);
		report_test("random tables", errors_before);

		errors_before = error_count;
		fill_saturation();
		write_all_tables();
		run_frame(0);
		report_test("saturation", errors_before);

		errors_before = error_count;
		run_frame(0);
		report_test("done and busy", errors_before);

		errors_before = error_count;
		run_frame(1);
		fill_random();
		write_all_tables();
		run_frame(0);
		report_test("start while busy", errors_before);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
